/* rtl/lane_cfg.svh */
`ifndef LANE_CFG_SVH
`define LANE_CFG_SVH

// *********************************************************************
// datapath geometry
// *********************************************************************

// bits per signed lane
`define LANE_WIDTH 18

// lanes processed in parallel
`define LANES 8

// fraction bits of the fixed-point format
`define FRAC_BITS 15

// register stages in the scale pipe, also the bias delay depth
// must be at least 2 (operand register plus multiply register)
`define MUL_STAGES 3

`endif

/* rtl/lane_data_pkg.sv */
`include "lane_cfg.svh"

package lane_data_pkg;

	// *********************************************************************
	// lane data words
	// *********************************************************************

	// one signed fixed-point lane
	typedef logic signed [`LANE_WIDTH-1:0] lane_word;

	// full vector of lanes, lane 0 in the low bits
	typedef struct packed {
		lane_word [`LANES-1:0] lane;
	} lane_vec;

	// full product of two lanes before the fraction shift
	typedef logic signed [2*`LANE_WIDTH-1:0] prod_word;

endpackage

/* rtl/lane_ctrl_pkg.sv */
package lane_ctrl_pkg;

	// *********************************************************************
	// opcodes and command words
	// *********************************************************************

	typedef enum logic [1:0] {
		OP_MAC    = 2'd0,
		OP_MUL    = 2'd1,
		OP_BYPASS = 2'd2
	} lane_op;

	// one command per input vector
	typedef struct packed {
		lane_op                  op;
		lane_data_pkg::lane_word coef;
	} lane_cmd;

	// control that rides with the product through the scale pipe
	typedef struct packed {
		logic   valid;
		lane_op op;
	} pipe_tag;

endpackage

/* rtl/lane_delay_line.sv */
`timescale 1ns/10ps

module lane_delay_line #(
	parameter int DEPTH = 1
) (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    enable,
	input  lane_data_pkg::lane_word d,
	output lane_data_pkg::lane_word q
);

	lane_data_pkg::lane_word stage [DEPTH];

	// shift one place per enabled edge
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < DEPTH; i++) begin
				stage[i] <= '0;
			end
		end else if (enable) begin
			stage[0] <= d;
			for (int i = 1; i < DEPTH; i++) begin
				stage[i] <= stage[i-1];
			end
		end
	end

	assign q = stage[DEPTH-1];

endmodule

/* rtl/lane_delay_group.sv */
`timescale 1ns/10ps
`include "lane_cfg.svh"

module lane_delay_group (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   enable,
	input  lane_data_pkg::lane_vec b,
	output lane_data_pkg::lane_vec b_aligned
);

	lane_data_pkg::lane_word q_lane [`LANES];

	// one delay line per lane, depth matched to the scale pipe
	for (genvar i = 0; i < `LANES; i++) begin : g_lane
		lane_delay_line #(
			.DEPTH(`MUL_STAGES)
		) u_line (
			.clk   (clk),
			.reset (reset),
			.enable(enable),
			.d     (b.lane[i]),
			.q     (q_lane[i])
		);
	end

	always_comb begin
		for (int i = 0; i < `LANES; i++) begin
			b_aligned.lane[i] = q_lane[i];
		end
	end

endmodule

/* rtl/lane_scale_pipe.sv */
`timescale 1ns/10ps
`include "lane_cfg.svh"

module lane_scale_pipe (
	input  logic                                  clk,
	input  logic                                  reset,
	input  logic                                  enable,
	input  logic                                  in_valid,
	input  lane_ctrl_pkg::lane_cmd                cmd,
	input  lane_data_pkg::lane_vec                x,
	output lane_data_pkg::prod_word [`LANES-1:0]  prod_vec,
	output lane_ctrl_pkg::pipe_tag                tag
);

	// product stages after the operand register
	localparam int CARRY = `MUL_STAGES - 1;

	lane_data_pkg::lane_vec                 x_r;
	lane_data_pkg::lane_word                coef_r;
	lane_data_pkg::prod_word [`LANES-1:0]   prod_r [CARRY];
	lane_ctrl_pkg::pipe_tag                 tag_r [`MUL_STAGES];

	// *********************************************************************
	// data path
	// *********************************************************************

	// stage 1 holds the operands
	always_ff @(posedge clk) begin
		if (enable) begin
			x_r    <= x;
			coef_r <= cmd.coef;
		end
	end

	// stage 2 multiplies, later stages only carry the product
	always_ff @(posedge clk) begin
		if (enable) begin
			for (int i = 0; i < `LANES; i++) begin
				prod_r[0][i] <= lane_data_pkg::prod_word'(x_r.lane[i]) *
					lane_data_pkg::prod_word'(coef_r);
			end
			for (int s = 1; s < CARRY; s++) begin
				prod_r[s] <= prod_r[s-1];
			end
		end
	end

	// *********************************************************************
	// tag path, lockstep with the data
	// *********************************************************************

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int s = 0; s < `MUL_STAGES; s++) begin
				tag_r[s] <= '0;
			end
		end else if (enable) begin
			tag_r[0] <= '{valid: in_valid, op: cmd.op};
			for (int s = 1; s < `MUL_STAGES; s++) begin
				tag_r[s] <= tag_r[s-1];
			end
		end
	end

	assign prod_vec = prod_r[CARRY-1];
	assign tag      = tag_r[`MUL_STAGES-1];

endmodule

/* rtl/lane_combine.sv */
`timescale 1ns/10ps
`include "lane_cfg.svh"

module lane_combine (
	input  logic                                 clk,
	input  logic                                 reset,
	input  logic                                 enable,
	input  lane_data_pkg::prod_word [`LANES-1:0] prod_vec,
	input  lane_ctrl_pkg::pipe_tag               tag,
	input  lane_data_pkg::lane_vec               b_aligned,
	output logic                                 out_valid,
	output lane_data_pkg::lane_vec               y
);

	// one guard bit over the product for the bias add
	localparam int SUM_W = 2*`LANE_WIDTH + 1;

	typedef logic signed [SUM_W-1:0] sum_t;

	localparam lane_data_pkg::lane_word LANE_MAX = {1'b0, {(`LANE_WIDTH-1){1'b1}}};
	localparam lane_data_pkg::lane_word LANE_MIN = {1'b1, {(`LANE_WIDTH-1){1'b0}}};

	sum_t                   scaled [`LANES];
	sum_t                   bias [`LANES];
	sum_t                   sum [`LANES];
	lane_data_pkg::lane_vec y_next;

	// floor shift, opcode select, add and clamp per lane
	always_comb begin
		for (int i = 0; i < `LANES; i++) begin
			scaled[i] = sum_t'(prod_vec[i] >>> `FRAC_BITS);
			bias[i]   = sum_t'(b_aligned.lane[i]);
			case (tag.op)
				lane_ctrl_pkg::OP_MAC:    sum[i] = scaled[i] + bias[i];
				lane_ctrl_pkg::OP_MUL:    sum[i] = scaled[i];
				lane_ctrl_pkg::OP_BYPASS: sum[i] = bias[i];
				default:                  sum[i] = '0;
			endcase
			if (sum[i] > sum_t'(LANE_MAX)) begin
				y_next.lane[i] = LANE_MAX;
			end else if (sum[i] < sum_t'(LANE_MIN)) begin
				y_next.lane[i] = LANE_MIN;
			end else begin
				y_next.lane[i] = sum[i][`LANE_WIDTH-1:0];
			end
		end
	end

	// y only moves on a valid result and otherwise keeps the last one
	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
			y         <= '0;
		end else if (enable) begin
			out_valid <= tag.valid;
			if (tag.valid) begin
				y <= y_next;
			end
		end
	end

endmodule

/* rtl/vec_affine_top.sv */
`timescale 1ns/10ps
`include "lane_cfg.svh"

module vec_affine_top (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   enable,
	input  logic                   in_valid,
	input  lane_ctrl_pkg::lane_cmd in_cmd,
	input  lane_data_pkg::lane_vec in_x,
	input  lane_data_pkg::lane_vec in_b,
	output logic                   out_valid,
	output lane_data_pkg::lane_vec out_y
);

	lane_data_pkg::prod_word [`LANES-1:0] prod_vec;
	lane_ctrl_pkg::pipe_tag               tag;
	lane_data_pkg::lane_vec               b_aligned;

	// *********************************************************************
	// x * coef, MUL_STAGES deep
	// *********************************************************************

	lane_scale_pipe u_scale (
		.clk     (clk),
		.reset   (reset),
		.enable  (enable),
		.in_valid(in_valid),
		.cmd     (in_cmd),
		.x       (in_x),
		.prod_vec(prod_vec),
		.tag     (tag)
	);

	// bias waits the same number of enabled edges
	lane_delay_group u_delay (
		.clk      (clk),
		.reset    (reset),
		.enable   (enable),
		.b        (in_b),
		.b_aligned(b_aligned)
	);

	// *********************************************************************
	// select, add, saturate, register
	// *********************************************************************

	lane_combine u_combine (
		.clk      (clk),
		.reset    (reset),
		.enable   (enable),
		.prod_vec (prod_vec),
		.tag      (tag),
		.b_aligned(b_aligned),
		.out_valid(out_valid),
		.y        (out_y)
	);

endmodule

/* testbench/vec_affine_tb.sv */
`timescale 1ns/10ps
`include "lane_cfg.svh"

module vec_affine_tb;

	localparam int PIPE = `MUL_STAGES + 1;
	localparam int STREAM_ITEMS = 200;
	// directed tests stay under 100 cycles, the stream under two cycles per item
	localparam int STIM_CYCLES = 5 + 100 + 2*STREAM_ITEMS;
	localparam longint LANE_MAX = (longint'(1) << (`LANE_WIDTH-1)) - 1;
	localparam longint LANE_MIN = -(longint'(1) << (`LANE_WIDTH-1));

	logic                   clk;
	logic                   reset;
	logic                   enable;
	logic                   in_valid;
	lane_ctrl_pkg::lane_cmd in_cmd;
	lane_data_pkg::lane_vec in_x;
	lane_data_pkg::lane_vec in_b;
	logic                   out_valid;
	lane_data_pkg::lane_vec out_y;

	lane_data_pkg::lane_vec exp_q [$];
	string                  name_q [$];
	string                  cur_test;
	logic [PIPE-1:0]        valid_sh;
	lane_data_pkg::lane_vec prev_y;
	lane_data_pkg::lane_vec head;
	string                  head_name;
	lane_data_pkg::lane_word exp_w;
	lane_data_pkg::lane_word act_w;
	lane_ctrl_pkg::lane_cmd cmd_v;
	lane_data_pkg::lane_vec xv;
	lane_data_pkg::lane_vec bv;
	logic                   armed;
	logic                   was_reset;
	logic                   was_enabled;
	int                     errors;
	int                     checked;
	int                     accepted;

	vec_affine_top dut (
		.clk      (clk),
		.reset    (reset),
		.enable   (enable),
		.in_valid (in_valid),
		.in_cmd   (in_cmd),
		.in_x     (in_x),
		.in_b     (in_b),
		.out_valid(out_valid),
		.out_y    (out_y)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// *********************************************************************
	// reference model: floor shift, select, add, clamp
	// *********************************************************************

	function automatic lane_data_pkg::lane_word model_lane(lane_ctrl_pkg::lane_op op,
			lane_data_pkg::lane_word x, lane_data_pkg::lane_word coef,
			lane_data_pkg::lane_word b);
		longint scaled;
		longint sum;
		scaled = (longint'(x) * longint'(coef)) >>> `FRAC_BITS;
		case (op)
			lane_ctrl_pkg::OP_MAC: sum = scaled + longint'(b);
			lane_ctrl_pkg::OP_MUL: sum = scaled;
			default:               sum = longint'(b);
		endcase
		if (sum > LANE_MAX) sum = LANE_MAX;
		if (sum < LANE_MIN) sum = LANE_MIN;
		return lane_data_pkg::lane_word'(sum);
	endfunction

	function automatic lane_data_pkg::lane_vec model_vec(lane_ctrl_pkg::lane_cmd cmd,
			lane_data_pkg::lane_vec x, lane_data_pkg::lane_vec b);
		lane_data_pkg::lane_vec r;
		for (int i = 0; i < `LANES; i++) begin
			r.lane[i] = model_lane(cmd.op, x.lane[i], cmd.coef, b.lane[i]);
		end
		return r;
	endfunction

	function automatic lane_data_pkg::lane_vec random_vec();
		lane_data_pkg::lane_vec r;
		for (int i = 0; i < `LANES; i++) begin
			r.lane[i] = lane_data_pkg::lane_word'($urandom);
		end
		return r;
	endfunction

	// *********************************************************************
	// monitor, checks the values seen just before each rising edge
	// *********************************************************************

	always @(posedge clk) begin
		if (armed) begin
			assert (out_valid === valid_sh[PIPE-1]) else begin
				errors++;
				if (out_valid === 1'b1)
					$display("unexpected out_valid in test %s at %0t", cur_test, $time);
				else
					$display("missing out_valid in test %s at %0t", cur_test, $time);
			end
			if (was_reset) begin
				assert (out_y === '0) else begin
					errors++;
					$display("** Error reset: expected %0h, actual %0h", '0, out_y);
				end
			end else if (!was_enabled) begin
				// stalled edge, the output register must hold
				assert (out_y === prev_y) else begin
					errors++;
					$display("** Error %s stall: expected %0h, actual %0h",
						cur_test, prev_y, out_y);
				end
			end
			// a new result only follows an enabled edge
			if (out_valid === 1'b1 && was_enabled && exp_q.size() == 0) begin
				errors++;
				$display("out_valid high with no result pending at %0t", $time);
			end else if (out_valid === 1'b1 && was_enabled) begin
				head = exp_q.pop_front();
				head_name = name_q.pop_front();
				checked++;
				for (int i = 0; i < `LANES; i++) begin
					exp_w = head.lane[i];
					act_w = out_y.lane[i];
					assert (act_w === exp_w) else begin
						errors++;
						$display("** Error %s lane %0d: expected %0d, actual %0d",
							head_name, i, exp_w, act_w);
					end
				end
			end
		end
		prev_y = out_y;
		if (reset) begin
			armed = 1'b1;
			was_reset = 1'b1;
			was_enabled = 1'b0;
			valid_sh = '0;
		end else begin
			was_reset = 1'b0;
			was_enabled = enable;
			if (enable) begin
				valid_sh = {valid_sh[PIPE-2:0], in_valid};
				if (in_valid) begin
					exp_q.push_back(model_vec(in_cmd, in_x, in_b));
					name_q.push_back(cur_test);
				end
			end
		end
	end

	// *********************************************************************
	// stimulus
	// *********************************************************************

	task automatic drive(input logic en, input logic vld);
		@(posedge clk);
		#1;
		enable = en;
		in_valid = vld;
		in_cmd = cmd_v;
		in_x = xv;
		in_b = bv;
	endtask

	// let every pending result come out
	task automatic drain();
		drive(1'b1, 1'b0);
		for (int n = 0; n < PIPE + 2 && exp_q.size() != 0; n++) begin
			@(posedge clk);
		end
		repeat (2) @(posedge clk);
	endtask

	initial begin
		void'($urandom(32'he229));
		armed = 1'b0;
		was_reset = 1'b0;
		was_enabled = 1'b0;
		valid_sh = '0;
		errors = 0;
		checked = 0;
		accepted = 0;
		reset = 1'b1;
		enable = 1'b1;
		in_valid = 1'b0;
		in_cmd = '0;
		in_x = '0;
		in_b = '0;
		cmd_v = '0;
		xv = '0;
		bv = '0;
		cur_test = "reset";
		repeat (5) @(posedge clk);
		#1;
		reset = 1'b0;

		cur_test = "latency";
		cmd_v.op = lane_ctrl_pkg::OP_MAC;
		cmd_v.coef = lane_data_pkg::lane_word'(16384);
		for (int i = 0; i < `LANES; i++) begin
			xv.lane[i] = lane_data_pkg::lane_word'(1000*i - 3000);
			bv.lane[i] = lane_data_pkg::lane_word'(7*i + 1);
		end
		drive(1'b1, 1'b1);
		drain();

		cur_test = "opcodes";
		cmd_v.op = lane_ctrl_pkg::OP_MUL;
		cmd_v.coef = lane_data_pkg::lane_word'(20001);
		for (int i = 0; i < `LANES; i++) begin
			xv.lane[i] = lane_data_pkg::lane_word'(-(4321*i + 777));
			bv.lane[i] = lane_data_pkg::lane_word'(-(1111*i + 5));
		end
		drive(1'b1, 1'b1);
		cmd_v.op = lane_ctrl_pkg::OP_BYPASS;
		drive(1'b1, 1'b1);
		drain();

		cur_test = "saturation";
		cmd_v.op = lane_ctrl_pkg::OP_MAC;
		cmd_v.coef = lane_data_pkg::lane_word'(LANE_MAX);
		for (int i = 0; i < `LANES; i++) begin
			xv.lane[i] = lane_data_pkg::lane_word'((i % 2 == 0) ? LANE_MAX : LANE_MIN);
			bv.lane[i] = xv.lane[i];
		end
		drive(1'b1, 1'b1);
		cmd_v.op = lane_ctrl_pkg::OP_MUL;
		drive(1'b1, 1'b1);
		drain();

		// enough items ahead of the stall that out_valid is high while frozen
		cur_test = "stall";
		cmd_v.op = lane_ctrl_pkg::OP_MAC;
		for (int n = 0; n < 5; n++) begin
			cmd_v.coef = lane_data_pkg::lane_word'($urandom);
			xv = random_vec();
			bv = random_vec();
			drive(1'b1, 1'b1);
		end
		for (int n = 0; n < 6; n++) begin
			xv = random_vec();
			drive(1'b0, 1'b1);
		end
		drain();

		cur_test = "stream";
		while (accepted < STREAM_ITEMS) begin
			cmd_v.op = lane_ctrl_pkg::lane_op'($urandom % 3);
			cmd_v.coef = lane_data_pkg::lane_word'($urandom);
			xv = random_vec();
			bv = random_vec();
			if ($urandom % 4 != 0) begin
				drive(1'b1, 1'b1);
				accepted++;
			end else begin
				drive(1'b0, 1'b1);
			end
		end
		drain();

		assert (exp_q.size() == 0) else begin
			errors++;
			$display("results still pending at the end of the run");
		end
		$display("results checked: %0d, errors: %0d", checked, errors);
		if (errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

	// watchdog
	initial begin
		repeat (STIM_CYCLES + 100) @(posedge clk);
		$display("timeout: results did not drain in test %s", cur_test);
		$display("STATUS: FAIL");
		$finish;
	end

endmodule

/* flist.f */
+incdir+rtl
rtl/lane_data_pkg.sv
rtl/lane_ctrl_pkg.sv
rtl/lane_delay_line.sv
rtl/lane_delay_group.sv
rtl/lane_scale_pipe.sv
rtl/lane_combine.sv
rtl/vec_affine_top.sv
testbench/vec_affine_tb.sv

/* Makefile */
TOOL  = verilator
FLAGS = --binary --timing --assert
TOP   = vec_affine_tb
FLIST = flist.f
RTL_TOP = vec_affine_top

BIN = obj_dir/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)

run: build
	@out=$$(./$(BIN)); \
	echo "$$out"; \
	echo "$$out" | grep -q "STATUS: PASS"

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf obj_dir
